// ==== include/sine_lut.svh ====
// one full electrical turn, 128 + 127 * sin(2 pi i / 64)
localparam logic [7:0] SINE_LUT [0:63] = '{
    // **************************************************
    // rising from mid-scale
    // **************************************************
    8'd128, 8'd140, 8'd153, 8'd165,
    8'd177, 8'd188, 8'd199, 8'd209,
    8'd218, 8'd226, 8'd234, 8'd240,
    8'd245, 8'd250, 8'd253, 8'd254,
    // peak at entry 16
    8'd255, 8'd254, 8'd253, 8'd250,
    8'd245, 8'd240, 8'd234, 8'd226,
    8'd218, 8'd209, 8'd199, 8'd188,
    8'd177, 8'd165, 8'd153, 8'd140,
    // **************************************************
    // negative half
    // **************************************************
    8'd128, 8'd116, 8'd103, 8'd91,
    8'd79,  8'd68,  8'd57,  8'd47,
    8'd38,  8'd30,  8'd22,  8'd16,
    8'd11,  8'd6,   8'd3,   8'd2,
    // trough at entry 48
    8'd1,   8'd2,   8'd3,   8'd6,
    8'd11,  8'd16,  8'd22,  8'd30,
    8'd38,  8'd47,  8'd57,  8'd68,
    8'd79,  8'd91,  8'd103, 8'd116
};

// ==== src/bus_pkg.sv ====
package bus_pkg;

    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // **************************************************
    // register map
    // **************************************************
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL     = 16'h0000; // enable bit 0, mode 9:8
    localparam logic [AXIL_ADDR_W-1:0] REG_VELOCITY = 16'h0004; // signed 16 bit
    localparam logic [AXIL_ADDR_W-1:0] REG_OFFSET   = 16'h0008; // low 6 bits
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 16'h000C; // u 5:0, v 13:8, w 21:16

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

// ==== src/motor_pkg.sv ====
package motor_pkg;

    // **************************************************
    // sine table and commutation constants
    // **************************************************
    localparam int TLEN_BITS = 6;
    localparam int TLEN      = 64;
    localparam int TMAX      = 16; // torque lead, a quarter turn
    localparam int TOFF_V    = 20;
    localparam int TOFF_W    = 41;

    localparam int FEEDBACK_SHIFT = 4; // encoder counts per table step is 16

    localparam int PWM_PRESCALE = 4;
    localparam int PWM_TOP      = 254; // 255 counts per period

    typedef enum logic [1:0] {
        MODE_RUN       = 2'd0,
        MODE_POSITION  = 2'd1,
        MODE_CALIBRATE = 2'd2
    } mode_t;

    typedef struct packed {
        logic                 enable;
        mode_t                mode;
        logic signed [15:0]   velocity;
        logic [TLEN_BITS-1:0] offset;
    } ctrl_t;

    typedef struct packed {
        logic [TLEN_BITS-1:0] u;
        logic [TLEN_BITS-1:0] v;
        logic [TLEN_BITS-1:0] w;
        logic [7:0]           voltage; // |velocity| clipped to 255
    } phase_pos_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] sine;
        logic [7:0] voltage;
    } mul_req_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] product;
    } mul_rsp_t;

endpackage

// ==== src/bldc_regs.sv ====
`timescale 1ns/1ns

module bldc_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bus_pkg::axil_req_t    axil_req,
    output bus_pkg::axil_rsp_t    axil_rsp,
    output motor_pkg::ctrl_t      ctrl,
    input  motor_pkg::phase_pos_t pos
);
    import bus_pkg::*;
    import motor_pkg::*;

    axil_rsp_t              rsp_q;
    ctrl_t                  ctrl_q;
    logic                   wr_fire;
    logic                   rd_fire;
    logic [AXIL_DATA_W-1:0] rd_word;

    assign axil_rsp = rsp_q;
    assign ctrl     = ctrl_q;

    assign wr_fire = rsp_q.awready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = rsp_q.arready && axil_req.arvalid;

    always_comb begin
        rd_word = '0; // unmapped reads return zero
        case (axil_req.araddr)
            REG_CTRL:     rd_word = {22'd0, ctrl_q.mode, 7'd0, ctrl_q.enable};
            REG_VELOCITY: rd_word = {16'd0, ctrl_q.velocity};
            REG_OFFSET:   rd_word = {26'd0, ctrl_q.offset};
            REG_STATUS:   rd_word = {10'd0, pos.w, 2'd0, pos.v, 2'd0, pos.u};
            default:      rd_word = '0;
        endcase
    end

    // **************************************************
    // write channel
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q  <= '0;
            ctrl_q <= '0;
        end else begin
            // accept a write only when no response is outstanding
            rsp_q.awready <= !rsp_q.bvalid && !rsp_q.awready &&
                             axil_req.awvalid && axil_req.wvalid;
            rsp_q.wready  <= !rsp_q.bvalid && !rsp_q.awready &&
                             axil_req.awvalid && axil_req.wvalid;
            if (wr_fire) begin
                rsp_q.bvalid <= 1'b1;
                rsp_q.bresp  <= RESP_OKAY;
                case (axil_req.awaddr)
                    REG_CTRL: begin
                        if (axil_req.wstrb[0]) ctrl_q.enable <= axil_req.wdata[0];
                        if (axil_req.wstrb[1]) ctrl_q.mode <= mode_t'(axil_req.wdata[9:8]);
                    end
                    REG_VELOCITY: begin
                        if (axil_req.wstrb[0]) ctrl_q.velocity[7:0] <= axil_req.wdata[7:0];
                        if (axil_req.wstrb[1]) ctrl_q.velocity[15:8] <= axil_req.wdata[15:8];
                    end
                    REG_OFFSET: begin
                        if (axil_req.wstrb[0]) ctrl_q.offset <= axil_req.wdata[TLEN_BITS-1:0];
                    end
                    default: ; // status and holes ignore writes
                endcase
            end else if (rsp_q.bvalid && axil_req.bready) begin
                rsp_q.bvalid <= 1'b0;
            end

            // read channel, status is sampled live at the address handshake
            rsp_q.arready <= !rsp_q.rvalid && !rsp_q.arready && axil_req.arvalid;
            if (rd_fire) begin
                rsp_q.rvalid <= 1'b1;
                rsp_q.rdata  <= rd_word;
                rsp_q.rresp  <= RESP_OKAY;
            end else if (rsp_q.rvalid && axil_req.rready) begin
                rsp_q.rvalid <= 1'b0;
            end
        end
    end

    // a write response always answers a write accepted the cycle before
    a_bvalid_after_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(rsp_q.bvalid) |-> $past(wr_fire)
    );

endmodule

// ==== src/commutation.sv ====
`timescale 1ns/1ns

module commutation (
    input  logic                  clk,
    input  logic                  rst_n,
    input  motor_pkg::ctrl_t      ctrl,
    input  logic [15:0]           feedback,
    output motor_pkg::phase_pos_t pos
);
    import motor_pkg::*;

    phase_pos_t           pos_q;
    logic [TLEN_BITS-1:0] fb_pos;
    logic [TLEN_BITS-1:0] lead;
    logic [TLEN_BITS-1:0] base;
    logic signed [16:0]   vel_ext;
    logic [16:0]          vel_abs;
    logic [7:0]           volt;

    assign pos = pos_q;

    assign fb_pos  = feedback[FEEDBACK_SHIFT +: TLEN_BITS];
    assign vel_ext = ctrl.velocity; // one extra bit so -32768 has a magnitude

    always_comb begin
        vel_abs = (vel_ext < 0) ? 17'(-vel_ext) : 17'(vel_ext);
        volt    = (vel_abs > 17'd255) ? 8'hFF : vel_abs[7:0];

        if (vel_ext > 0) begin
            lead = TLEN_BITS'(TMAX);
        end else if (vel_ext < 0) begin
            lead = TLEN_BITS'(TLEN - TMAX); // lead of -TMAX, modulo the table length
        end else begin
            lead = '0;
        end

        case (ctrl.mode)
            MODE_POSITION:  base = ctrl.offset; // open loop, feedback not used
            MODE_CALIBRATE: base = fb_pos + ctrl.offset;
            default:        base = fb_pos + ctrl.offset + lead;
        endcase
    end

    // all three positions and the voltage move together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_q <= '0;
        end else begin
            pos_q.u       <= base;
            pos_q.v       <= base + TLEN_BITS'(TOFF_V);
            pos_q.w       <= base + TLEN_BITS'(TOFF_W);
            pos_q.voltage <= volt;
        end
    end

endmodule

// ==== src/mult_share.sv ====
`timescale 1ns/1ns

module mult_share (
    input  logic                clk,
    input  logic                rst_n,
    input  motor_pkg::mul_req_t req [3],
    output motor_pkg::mul_rsp_t rsp [3]
);
    import motor_pkg::*;

    logic [1:0]  last_q;
    logic [2:0]  vld_q;
    logic [15:0] prod_q;
    logic [1:0]  grant_idx;
    logic        grant_vld;
    logic [2:0]  pending;

    // a requester whose product is on the output this cycle still shows valid
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            pending[i] = req[i].valid && !vld_q[i];
        end
    end

    // **************************************************
    // round-robin pick, starting after the last grant
    // **************************************************
    always_comb begin
        int unsigned cand;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= 3; k++) begin
            cand = (int'(last_q) + k) % 3;
            if (!grant_vld && pending[cand]) begin
                grant_vld = 1'b1;
                grant_idx = 2'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= 2'd2; // channel 0 wins first
            vld_q  <= '0;
        end else begin
            vld_q <= '0;
            if (grant_vld) begin
                vld_q[grant_idx] <= 1'b1;
                last_q           <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_vld) begin
            prod_q <= {8'd0, req[grant_idx].sine} * {8'd0, req[grant_idx].voltage};
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            rsp[i].valid   = vld_q[i];
            rsp[i].product = prod_q;
        end
    end

    a_one_rsp: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({rsp[2].valid, rsp[1].valid, rsp[0].valid})
    );

endmodule

// ==== src/pwm_timebase.sv ====
`timescale 1ns/1ns

module pwm_timebase (
    input  logic       clk,
    input  logic       rst_n,
    output logic [7:0] count,
    output logic       period_start
);
    import motor_pkg::*;

    logic [$clog2(PWM_PRESCALE)-1:0] pre_q;

    // period_start is high in the first clock of count 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_q        <= '0;
            count        <= '0;
            period_start <= 1'b0;
        end else begin
            period_start <= 1'b0;
            if (pre_q == $bits(pre_q)'(PWM_PRESCALE - 1)) begin
                pre_q <= '0;
                if (count == 8'(PWM_TOP)) begin
                    count        <= '0;
                    period_start <= 1'b1;
                end else begin
                    count <= count + 8'd1;
                end
            end else begin
                pre_q <= pre_q + 1'b1;
            end
        end
    end

endmodule

// ==== src/phase_channel.sv ====
`timescale 1ns/1ns

module phase_channel (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic [7:0]                     count,
    input  logic                           period_start,
    input  logic [motor_pkg::TLEN_BITS-1:0] position,
    input  logic [7:0]                     voltage,
    output motor_pkg::mul_req_t            mul_req,
    input  motor_pkg::mul_rsp_t            mul_rsp,
    output logic                           gate_p,
    output logic                           gate_n
);
    import motor_pkg::*;

    `include "sine_lut.svh"

    logic                 busy_q;
    logic [TLEN_BITS-1:0] pos_q;
    logic [7:0]           volt_q;
    logic [7:0]           sine_q;
    logic [7:0]           duty_pend_q;
    logic [7:0]           duty_act_q;
    logic                 stale;
    logic                 issue;

    // operands of the last request no longer match the inputs
    assign stale = (position != pos_q) || (voltage != volt_q);
    assign issue = stale && (!busy_q || mul_rsp.valid);

    assign mul_req.valid   = busy_q;
    assign mul_req.sine    = sine_q;
    assign mul_req.voltage = volt_q;

    // **************************************************
    // product request and duty latch
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            pos_q       <= '0;
            volt_q      <= '0;
            duty_pend_q <= '0;
            duty_act_q  <= '0;
        end else begin
            if (mul_rsp.valid) begin
                duty_pend_q <= mul_rsp.product[15:8]; // scale back to 8 bits
            end
            if (period_start) begin
                duty_act_q <= duty_pend_q;
            end
            if (issue) begin
                busy_q <= 1'b1;
                pos_q  <= position;
                volt_q <= voltage;
            end else if (mul_rsp.valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            sine_q <= SINE_LUT[position];
        end
    end

    assign gate_p = enable && (count < duty_act_q);
    assign gate_n = enable && !(count < duty_act_q);

    a_no_shoot_through: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(gate_p && gate_n)
    );

endmodule

// ==== src/bldc_top.sv ====
`timescale 1ns/1ns

module bldc_top (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::axil_req_t axil_req,
    input  logic [15:0]        feedback,
    output bus_pkg::axil_rsp_t axil_rsp,
    output logic               en,
    output logic               u_p,
    output logic               v_p,
    output logic               w_p,
    output logic               u_n,
    output logic               v_n,
    output logic               w_n
);
    import motor_pkg::*;

    ctrl_t      ctrl;
    phase_pos_t pos;
    mul_req_t   mul_req [3];
    mul_rsp_t   mul_rsp [3];
    logic [7:0] count;
    logic       period_start;

    assign en = ctrl.enable;

    bldc_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .ctrl     (ctrl),
        .pos      (pos)
    );

    commutation u_commutation (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .feedback (feedback),
        .pos      (pos)
    );

    mult_share u_mult_share (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mul_req),
        .rsp   (mul_rsp)
    );

    pwm_timebase u_pwm_timebase (
        .clk          (clk),
        .rst_n        (rst_n),
        .count        (count),
        .period_start (period_start)
    );

    // **************************************************
    // phase channels, 0 = u, 1 = v, 2 = w on the multiplier
    // **************************************************
    phase_channel u_phase (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (ctrl.enable),
        .count        (count),
        .period_start (period_start),
        .position     (pos.u),
        .voltage      (pos.voltage),
        .mul_req      (mul_req[0]),
        .mul_rsp      (mul_rsp[0]),
        .gate_p       (u_p),
        .gate_n       (u_n)
    );

    phase_channel v_phase (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (ctrl.enable),
        .count        (count),
        .period_start (period_start),
        .position     (pos.v),
        .voltage      (pos.voltage),
        .mul_req      (mul_req[1]),
        .mul_rsp      (mul_rsp[1]),
        .gate_p       (v_p),
        .gate_n       (v_n)
    );

    phase_channel w_phase (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (ctrl.enable),
        .count        (count),
        .period_start (period_start),
        .position     (pos.w),
        .voltage      (pos.voltage),
        .mul_req      (mul_req[2]),
        .mul_rsp      (mul_rsp[2]),
        .gate_p       (w_p),
        .gate_n       (w_n)
    );

endmodule

// ==== bench/bldc_tb.sv ====
`timescale 1ns/1ns

module bldc_tb;
    import bus_pkg::*;
    import motor_pkg::*;

    `include "sine_lut.svh"

    localparam int NUM_ROWS    = 8;
    localparam int CLK_HALF    = 10;
    localparam int SETTLE_CLKS = 2040;
    localparam int PERIOD_CLKS = PWM_PRESCALE * (PWM_TOP + 1); // one full PWM period
    localparam int WATCHDOG    = NUM_ROWS * 4000 + 2000;

    typedef struct packed {
        logic               enable;
        logic [1:0]         mode;
        logic signed [15:0] velocity;
        logic [5:0]         offset;
        logic [15:0]        feedback;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [15:0] feedback;
    logic        en;
    logic        u_p;
    logic        v_p;
    logic        w_p;
    logic        u_n;
    logic        v_n;
    logic        w_n;

    test_row_t rows [NUM_ROWS];
    int        errors;
    int        row_errors;
    int        checks;
    int        rows_ok;

    bldc_top u_bldc_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .feedback (feedback),
        .axil_rsp (axil_rsp),
        .en       (en),
        .u_p      (u_p),
        .v_p      (v_p),
        .w_p      (w_p),
        .u_n      (u_n),
        .v_n      (v_n),
        .w_n      (w_n)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the run did not finish within %0d clocks", WATCHDOG);
        $display("tests failed");
        $finish;
    end

    // **************************************************
    // stimulus table and expected values
    // **************************************************
    task automatic fill_table();
        rows[0] = '{1'b1, MODE_POSITION,  16'sd100,  6'd5,  16'h0000};
        rows[1] = '{1'b1, MODE_POSITION,  16'sd200,  6'd50, 16'h1234}; // v and w wrap
        rows[2] = '{1'b1, MODE_RUN,       16'sd150,  6'd10, 16'h0120};
        rows[3] = '{1'b1, MODE_RUN,      -16'sd120,  6'd3,  16'h0350};
        rows[4] = '{1'b1, MODE_RUN,       16'sd0,    6'd7,  16'h0200}; // no lead, zero duty
        rows[5] = '{1'b1, MODE_RUN,       16'sd400,  6'd60, 16'h03F0}; // voltage saturates
        rows[6] = '{1'b1, MODE_CALIBRATE, -16'sd300, 6'd33, 16'h0A70};
        rows[7] = '{1'b0, MODE_RUN,       16'sd180,  6'd12, 16'h0100}; // gates off
    endtask

    function automatic int expected_voltage(test_row_t r);
        int vel;
        vel = $signed(r.velocity);
        if (vel < 0) vel = -vel;
        return (vel > 255) ? 255 : vel;
    endfunction

    function automatic int expected_u(test_row_t r);
        int vel;
        int lead;
        int base;
        vel  = $signed(r.velocity);
        lead = (vel > 0) ? 16 : ((vel < 0) ? 48 : 0);
        if (r.mode == MODE_POSITION) begin
            base = r.offset;
        end else if (r.mode == MODE_CALIBRATE) begin
            base = (r.feedback >> 4) + r.offset;
        end else begin
            base = (r.feedback >> 4) + r.offset + lead;
        end
        return base % 64;
    endfunction

    function automatic int expected_duty(int pos, int volt);
        return (int'(SINE_LUT[pos % 64]) * volt) >> 8;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
            row_errors++;
        end
    endtask

    // **************************************************
    // AXI4-Lite master tasks start 2 ns after a rising edge
    // **************************************************
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        @(posedge clk); #2;
        while (!axil_rsp.awready) begin
            @(posedge clk); #2;
        end
        check_value("wready", {31'd0, axil_rsp.wready}, 32'd1);
        @(posedge clk); #2; // the write is taken at this edge
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) begin
            @(posedge clk); #2;
        end
        resp = axil_rsp.bresp;
        @(posedge clk); #2;
        axil_req.bready = 1'b0;
        check_value("bresp", {30'd0, resp}, {30'd0, RESP_OKAY});
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        @(posedge clk); #2;
        while (!axil_rsp.arready) begin
            @(posedge clk); #2;
        end
        @(posedge clk); #2;
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) begin
            @(posedge clk); #2;
        end
        data = axil_rsp.rdata;
        check_value("rresp", {30'd0, axil_rsp.rresp}, {30'd0, RESP_OKAY});
        @(posedge clk); #2;
        axil_req.rready = 1'b0;
    endtask

    task automatic check_reset_state();
        row_errors = 0;
        checks++;
        assert (!en && !u_p && !v_p && !w_p && !u_n && !v_n && !w_n &&
                !axil_rsp.bvalid && !axil_rsp.rvalid && !axil_rsp.awready &&
                !axil_rsp.wready && !axil_rsp.arready) else begin
            $display("gate outputs or bus handshakes are not low after reset");
            row_errors++;
        end
        $display("reset state: %s", (row_errors == 0) ? "ok" : "FAILED");
        errors += row_errors;
    endtask

    task automatic run_row(input int idx);
        test_row_t   r;
        logic [31:0] rd;
        int          u;
        int          volt;
        int          u_hi;
        int          v_hi;
        int          w_hi;
        int          faults;
        r          = rows[idx];
        row_errors = 0;
        u_hi       = 0;
        v_hi       = 0;
        w_hi       = 0;
        faults     = 0;
        feedback   = r.feedback;
        axil_write(REG_CTRL, {22'd0, r.mode, 7'd0, r.enable});
        axil_write(REG_VELOCITY, {16'd0, r.velocity});
        axil_write(REG_OFFSET, {26'd0, r.offset});
        axil_read(REG_CTRL, rd);
        check_value("ctrl", rd, {22'd0, r.mode, 7'd0, r.enable});
        axil_read(REG_VELOCITY, rd);
        check_value("velocity", rd, {16'd0, r.velocity});
        axil_read(REG_OFFSET, rd);
        check_value("offset", rd, {26'd0, r.offset});

        repeat (SETTLE_CLKS) @(posedge clk);
        #2;
        u    = expected_u(r);
        volt = expected_voltage(r);
        axil_read(REG_STATUS, rd);
        check_value("status u", {26'd0, rd[5:0]}, u % 64);
        check_value("status v", {26'd0, rd[13:8]}, (u + TOFF_V) % 64);
        check_value("status w", {26'd0, rd[21:16]}, (u + TOFF_W) % 64);

        for (int c = 0; c < PERIOD_CLKS; c++) begin
            @(posedge clk); #2;
            if (u_p) u_hi++;
            if (v_p) v_hi++;
            if (w_p) w_hi++;
            if (r.enable) begin
                if (!(u_p ^ u_n) || !(v_p ^ v_n) || !(w_p ^ w_n) || !en) faults++;
            end else if (en || u_p || v_p || w_p || u_n || v_n || w_n) begin
                faults++;
            end
        end
        if (r.enable) begin
            check_value("u_p high clocks", u_hi, 4 * expected_duty(u, volt));
            check_value("v_p high clocks", v_hi, 4 * expected_duty(u + TOFF_V, volt));
            check_value("w_p high clocks", w_hi, 4 * expected_duty(u + TOFF_W, volt));
        end
        checks++;
        assert (faults == 0) else begin
            $display("gate outputs or en wrong for enable %0d in %0d clocks of row %0d",
                     r.enable, faults, idx);
            row_errors++;
        end

        $display("row %0d mode %0d velocity %0d offset %0d: %s", idx, r.mode,
                 $signed(r.velocity), r.offset, (row_errors == 0) ? "ok" : "FAILED");
        errors += row_errors;
        if (row_errors == 0) rows_ok++;
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        rows_ok  = 0;
        rst_n    = 1'b0;
        axil_req = '0;
        feedback = '0;
        fill_table();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset_state();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("rows ok %0d of %0d, checks %0d, errors %0d", rows_ok, NUM_ROWS, checks,
                 errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
src/bus_pkg.sv
src/motor_pkg.sv
src/bldc_regs.sv
src/commutation.sv
src/mult_share.sv
src/pwm_timebase.sv
src/phase_channel.sv
src/bldc_top.sv
bench/bldc_tb.sv
